//--- flist.f
arcade_video_pkg.sv
pixel_capture.sv
screen_rotate.sv
video_out_select.sv
arcade_rotate_fx.sv
tb_arcade_rotate.sv

//--- tb_arcade_rotate.sv
`timescale 1ns/1ns
// Testbench for the rotating arcade video stage
//   Frame generator with active-low line sync, reference functions,
//   checker process on vid_out.ce and typed compare tasks
//   Covers reset, direct path, sync polarity, CW and CCW rotation

module tb_arcade_rotate;
    import arcade_video_pkg::*;

    localparam int WIDTH  = 16;
    localparam int HEIGHT = 8;
    localparam int DW     = 12;
    localparam int LINE_PIX = 22;
    localparam int FRAME_LINES = 11;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          ce_pix;
    logic [DW-1:0] pix_in;
    video_ctl_t    ctl_in;
    logic          out_ce;
    rot_dir_t      rotate_ccw;
    logic          no_rotate;
    video_out_t    vid_out;

    // Generator state, next_* take effect at a frame start
    logic [DW-1:0] next_base;
    logic [DW-1:0] gen_base;
    rot_dir_t      next_dir;
    logic          next_direct;
    int            frames_sent = 0;
    int            out_cnt = 0;
    logic [DW-1:0] direct_q[$];

    // Checker state
    logic hs_chk = 1'b0;
    logic rot_armed = 1'b0;
    logic in_frame = 1'b0;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    logic line_seen = 1'b0;
    int   since_hs = 0;
    int   hs_run = 0;
    int   de_run = 0;
    int   pix_cnt = 0;
    int   rot_frames = 0;

    arcade_rotate_fx #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT),
        .DW     (DW)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ce_pix     (ce_pix),
        .pix_in     (pix_in),
        .ctl_in     (ctl_in),
        .out_ce     (out_ce),
        .rotate_ccw (rotate_ccw),
        .no_rotate  (no_rotate),
        .vid_out    (vid_out)
    );

    always #20 clk = ~clk;

    // ============================================================
    // Reference functions
    // ============================================================

    function automatic logic [DW-1:0] pix_at(input int x, input int y, input logic [DW-1:0] base);
        return DW'(x + 16 * y) + base;
    endfunction

    function automatic logic [7:0] expand4(input logic [3:0] c);
        return 8'(c * 17);
    endfunction

    function automatic rgb888_t to_rgb(input logic [DW-1:0] p);
        rgb888_t v;
        v.r = expand4(p[11:8]);
        v.g = expand4(p[7:4]);
        v.b = expand4(p[3:0]);
        return v;
    endfunction

    // Source pixel of output (line, col) after the turn
    function automatic void rot_src(input int line, input int col, input rot_dir_t dir,
                                    output int x, output int y);
        if (dir == ROT_CW) begin
            x = line;
            y = HEIGHT - 1 - col;
        end else begin
            x = WIDTH - 1 - line;
            y = col;
        end
    endfunction

    // ============================================================
    // Compare tasks and failure
    // ============================================================

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_rgb(input string name, input rgb888_t exp, input rgb888_t act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            fail_now("rgb mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            fail_now("bit mismatch");
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================

    // Scaler side enable, one cycle in three
    always @(negedge clk) begin
        out_cnt <= (out_cnt == 2) ? 0 : out_cnt + 1;
        out_ce  <= (out_cnt == 2);
    end

    task automatic drive_pixel(input int x, input int y);
        @(negedge clk);
        ce_pix     = 1'b1;
        pix_in     = pix_at(x, y, gen_base);
        ctl_in.hbl = (x >= WIDTH);
        ctl_in.vbl = (y >= HEIGHT);
        ctl_in.hs  = !(x == 18 || x == 19);
        ctl_in.vs  = (y == 9);
        if (no_rotate && x < WIDTH && y < HEIGHT) begin
            direct_q.push_back(pix_in);
        end
        @(negedge clk);
        ce_pix = 1'b0;
    endtask

    task automatic run_frames();
        forever begin
            gen_base   = next_base;
            rotate_ccw = next_dir;
            no_rotate  = next_direct;
            for (int y = 0; y < FRAME_LINES; y++) begin
                for (int x = 0; x < LINE_PIX; x++) begin
                    drive_pixel(x, y);
                end
            end
            frames_sent++;
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        int t;
        target = frames_sent + n;
        t = 0;
        while (frames_sent < target) begin
            @(posedge clk);
            t++;
            if (t > n * 600 + 1000) fail_now("Timeout waiting for input frames");
        end
    endtask

    task automatic wait_rot_frames(input int n);
        int t;
        t = 0;
        while (rot_frames < n) begin
            @(posedge clk);
            t++;
            if (t > 12000) fail_now("Timeout waiting for rotated output frames");
        end
    endtask

    // ============================================================
    // Checker
    // ============================================================

    always @(posedge clk) begin
        int x;
        int y;
        if (rst_n && vid_out.ce) begin
            if (no_rotate) begin
                if (vid_out.de) begin
                    if (direct_q.size() == 0) fail_now("Direct path gave a pixel never sent");
                    check_rgb("direct pixel", to_rgb(direct_q.pop_front()), vid_out.rgb);
                end
                if (hs_chk) begin
                    if (vid_out.hs && !hs_prev) begin
                        if (line_seen && since_hs != LINE_PIX) begin
                            fail_now("Direct hs pulse count per line is wrong");
                        end
                        since_hs  = 0;
                        line_seen = 1'b1;
                    end
                    since_hs++;
                    hs_run = vid_out.hs ? hs_run + 1 : 0;
                    if (hs_run > 2) fail_now("Direct hs pulse wider than input sync");
                end else begin
                    line_seen = 1'b0;
                end
            end else begin
                if (vid_out.vs && !vs_prev) begin
                    if (in_frame) begin
                        if (pix_cnt != WIDTH * HEIGHT) fail_now("Wrong de count in output frame");
                        rot_frames++;
                    end
                    in_frame = rot_armed;
                    pix_cnt  = 0;
                    de_run   = 0;
                end
                if (in_frame && vid_out.de) begin
                    if (pix_cnt >= WIDTH * HEIGHT) fail_now("de high outside active lines");
                    rot_src(pix_cnt / HEIGHT, pix_cnt % HEIGHT, next_dir, x, y);
                    check_rgb(next_dir == ROT_CW ? "cw pixel" : "ccw pixel",
                              to_rgb(pix_at(x, y, next_base)), vid_out.rgb);
                    pix_cnt++;
                end
                // Each rotated line carries HEIGHT de pixels in one run
                if (in_frame) begin
                    if (vid_out.de) begin
                        de_run++;
                    end else if (de_run != 0) begin
                        if (de_run != HEIGHT) fail_now("Rotated line has a wrong de pixel count");
                        de_run = 0;
                    end
                end
            end
            hs_prev = vid_out.hs;
            vs_prev = vid_out.vs;
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        rst_n       = 1'b0;
        ce_pix      = 1'b0;
        pix_in      = '0;
        ctl_in      = '{hs: 1'b1, vs: 1'b0, hbl: 1'b1, vbl: 1'b1};
        out_ce      = 1'b0;
        rotate_ccw  = ROT_CW;
        no_rotate   = 1'b1;
        next_dir    = ROT_CW;
        next_direct = 1'b1;
        next_base   = DW'($urandom(32'h56bb832c));
        gen_base    = next_base;

        // Reset holds the output idle
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_bit("reset ce", 1'b0, vid_out.ce);
            check_bit("reset de", 1'b0, vid_out.de);
            check_bit("reset hs", 1'b0, vid_out.hs);
            check_bit("reset vs", 1'b0, vid_out.vs);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("post reset ce", 1'b0, vid_out.ce);
        check_bit("post reset de", 1'b0, vid_out.de);
        check_bit("post reset hs", 1'b0, vid_out.hs);
        check_bit("post reset vs", 1'b0, vid_out.vs);

        fork
            run_frames();
        join_none

        // Direct path, hs checked once polarity has settled
        wait_frames(2);
        hs_chk = 1'b1;
        wait_frames(3);
        hs_chk = 1'b0;
        if (direct_q.size() != 0) fail_now("Direct pixels missing from output");

        // Clockwise
        next_direct = 1'b0;
        next_dir    = ROT_CW;
        next_base   = DW'($urandom());
        wait_frames(7);
        rot_armed = 1'b1;
        wait_rot_frames(2);
        rot_armed = 1'b0;
        in_frame  = 1'b0;

        // Counter-clockwise
        rot_frames = 0;
        next_dir   = ROT_CCW;
        next_base  = DW'($urandom());
        wait_frames(7);
        rot_armed = 1'b1;
        wait_rot_frames(2);

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- arcade_rotate_fx.sv
`timescale 1ns/1ns
// Video output stage for vertical-screen arcade cores
//   pixel_capture -> screen_rotate -> video_out_select
//   Pixel word formats by DW: 6 (2-2-2), 8 (3-3-2), 9 (3-3-3), 12 (4-4-4)

module arcade_rotate_fx
    import arcade_video_pkg::*;
#(
    parameter int WIDTH  = 320,
    parameter int HEIGHT = 240,
    parameter int DW     = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          ce_pix,
    input  logic [DW-1:0] pix_in,
    input  video_ctl_t    ctl_in,
    input  logic          out_ce,
    input  rot_dir_t      rotate_ccw,
    input  logic          no_rotate,
    output video_out_t    vid_out
);

    logic          cap_ce;
    logic [DW-1:0] cap_pix;
    video_ctl_t    cap_ctl;
    logic [DW-1:0] rot_pix;
    video_ctl_t    rot_ctl;

    pixel_capture #(
        .DW (DW)
    ) i_capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .ce_pix  (ce_pix),
        .pix_in  (pix_in),
        .ctl_in  (ctl_in),
        .cap_ce  (cap_ce),
        .cap_pix (cap_pix),
        .cap_ctl (cap_ctl)
    );

    // Frame store, paced on the output side by the scaler
    screen_rotate #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT),
        .DW     (DW)
    ) i_rotate (
        .clk        (clk),
        .rst_n      (rst_n),
        .cap_ce     (cap_ce),
        .cap_pix    (cap_pix),
        .cap_ctl    (cap_ctl),
        .rotate_ccw (rotate_ccw),
        .out_ce     (out_ce),
        .rot_pix    (rot_pix),
        .rot_ctl    (rot_ctl)
    );

    video_out_select #(
        .DW (DW)
    ) i_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .no_rotate (no_rotate),
        .cap_ce    (cap_ce),
        .cap_pix   (cap_pix),
        .cap_ctl   (cap_ctl),
        .out_ce    (out_ce),
        .rot_pix   (rot_pix),
        .rot_ctl   (rot_ctl),
        .vid_out   (vid_out)
    );

endmodule

//--- video_out_select.sv
`timescale 1ns/1ns
// Output stage
//   Direct or rotated stream chosen by no_rotate
//   Channel widening to 8 bits by repeating the top bits
//   Registered video output

module video_out_select
    import arcade_video_pkg::*;
#(
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          no_rotate,
    input  logic          cap_ce,
    input  logic [DW-1:0] cap_pix,
    input  video_ctl_t    cap_ctl,
    input  logic          out_ce,
    input  logic [DW-1:0] rot_pix,
    input  video_ctl_t    rot_ctl,
    output video_out_t    vid_out
);

    // 6: 2-2-2, 8: 3-3-2, 9: 3-3-3, 12: 4-4-4
    localparam int R_BITS = (DW == 6) ? 2 : (DW == 12) ? 4 : 3;
    localparam int G_BITS = R_BITS;
    localparam int B_BITS = (DW == 6 || DW == 8) ? 2 : (DW == 12) ? 4 : 3;

    logic          out_ce_d;
    logic          sel_ce;
    logic [DW-1:0] sel_pix;
    video_ctl_t    sel_ctl;
    rgb888_t       sel_rgb;

    logic          ce_q;
    rgb888_t       rgb_q;
    logic          hs_q;
    logic          vs_q;
    logic          de_q;

    // Repeats an n-bit channel across 8 bits, MSB first
    function automatic logic [7:0] widen(input logic [3:0] c, input int n);
        logic [7:0] v;
        int         i;
        for (i = 0; i < 8; i++) begin
            v[7-i] = c[n-1-(i%n)];
        end
        return v;
    endfunction

    // Rotated data is valid the cycle after its out_ce
    assign sel_ce  = no_rotate ? cap_ce  : out_ce_d;
    assign sel_pix = no_rotate ? cap_pix : rot_pix;
    assign sel_ctl = no_rotate ? cap_ctl : rot_ctl;

    assign sel_rgb.r = widen(4'(sel_pix[DW-1 -: R_BITS]), R_BITS);
    assign sel_rgb.g = widen(4'(sel_pix[B_BITS+G_BITS-1 -: G_BITS]), G_BITS);
    assign sel_rgb.b = widen(4'(sel_pix[B_BITS-1:0]), B_BITS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_ce_d <= 1'b0;
            ce_q     <= 1'b0;
            hs_q     <= 1'b0;
            vs_q     <= 1'b0;
            de_q     <= 1'b0;
        end else begin
            out_ce_d <= out_ce;
            ce_q     <= sel_ce;
            if (sel_ce) begin
                hs_q <= sel_ctl.hs;
                vs_q <= sel_ctl.vs;
                de_q <= ~(sel_ctl.hbl | sel_ctl.vbl);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_ce) begin
            rgb_q <= sel_rgb;
        end
    end

    assign vid_out = '{ce: ce_q, rgb: rgb_q, hs: hs_q, vs: vs_q, de: de_q};

    assert property (@(posedge clk) disable iff (!rst_n) !(vid_out.de && vid_out.vs))
        else $error("display enable during vertical sync");

endmodule

//--- screen_rotate.sv
`timescale 1ns/1ns
// Rotating frame store
//   Two frame buffers of WIDTH x HEIGHT words in one RAM
//   Write side stores input lines as columns, CW or CCW
//   Read side runs its own raster of HEIGHT-pixel lines on out_ce
//   A new input frame is dropped while both buffers are in use

module screen_rotate
    import arcade_video_pkg::*;
#(
    parameter int WIDTH  = 320,
    parameter int HEIGHT = 240,
    parameter int DW     = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cap_ce,
    input  logic [DW-1:0] cap_pix,
    input  video_ctl_t    cap_ctl,
    input  rot_dir_t      rotate_ccw,
    input  logic          out_ce,
    output logic [DW-1:0] rot_pix,
    output video_ctl_t    rot_ctl
);

    localparam int BUF_SIZE = WIDTH * HEIGHT;
    localparam int AW       = $clog2(2 * BUF_SIZE);
    localparam int XW       = $clog2(WIDTH + 1);
    localparam int YW       = $clog2(HEIGHT + 1);
    localparam int LINE_LEN = HEIGHT + 18;
    localparam int COL_W    = $clog2(LINE_LEN);
    localparam int ROW_W    = $clog2(WIDTH + 2);

    localparam logic [AW-1:0] BUF_BASE  = AW'(BUF_SIZE);
    localparam logic [AW-1:0] BUF_LAST  = AW'(BUF_SIZE - 1);
    localparam logic [AW-1:0] STEP      = AW'(HEIGHT);
    localparam logic [AW-1:0] CW_START  = AW'(HEIGHT - 1);
    localparam logic [AW-1:0] CCW_START = AW'((WIDTH - 1) * HEIGHT);

    logic [DW-1:0] ram [2*BUF_SIZE];

    // Write side
    logic          blank;
    logic          blank_q;
    logic          vbl_q;
    logic          line_end;
    logic          frame_end;
    logic          swap;
    logic          we;
    logic          wr_buf;
    logic          frame_ok;
    logic          pending;
    rot_dir_t      dir;
    logic [XW-1:0] xpos;
    logic [YW-1:0] ypos;
    logic [AW-1:0] row_off;
    logic [AW-1:0] wr_off;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] start_off;

    // Read side
    logic             restart;
    logic             line_last;
    logic             active;
    logic             rd_buf;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic [AW-1:0]    rd_off;
    logic [AW-1:0]    rd_addr;
    logic [DW-1:0]    rd_data;

    // ============================================================
    // Write side
    // ============================================================

    assign blank     = cap_ctl.hbl | cap_ctl.vbl;
    assign line_end  = cap_ce & blank & ~blank_q;
    assign frame_end = cap_ce & cap_ctl.vbl & ~vbl_q;
    assign swap      = frame_end & frame_ok;
    assign we        = cap_ce & ~blank & frame_ok
                     & (xpos < XW'(WIDTH)) & (ypos < YW'(HEIGHT));
    assign wr_addr   = (wr_buf ? BUF_BASE : '0) + wr_off;
    assign start_off = (rotate_ccw == ROT_CCW) ? CCW_START : CW_START;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blank_q  <= 1'b1;
            vbl_q    <= 1'b1;
            wr_buf   <= 1'b0;
            frame_ok <= 1'b0;
            pending  <= 1'b0;
            dir      <= ROT_CW;
            xpos     <= '0;
            ypos     <= '0;
            row_off  <= '0;
            wr_off   <= '0;
        end else begin
            if (cap_ce) begin
                blank_q <= blank;
                vbl_q   <= cap_ctl.vbl;
            end
            if (we) begin
                wr_off <= (dir == ROT_CCW) ? wr_off - STEP : wr_off + STEP;
                xpos   <= xpos + 1'b1;
            end
            // Each input line lands in the neighbouring column
            if (line_end) begin
                xpos    <= '0;
                row_off <= (dir == ROT_CCW) ? row_off + 1'b1 : row_off - 1'b1;
                wr_off  <= (dir == ROT_CCW) ? row_off + 1'b1 : row_off - 1'b1;
                if (ypos != YW'(HEIGHT)) begin
                    ypos <= ypos + 1'b1;
                end
            end
            if (restart) begin
                pending <= 1'b0;
            end
            if (frame_end) begin
                dir      <= rotate_ccw;
                xpos     <= '0;
                ypos     <= '0;
                row_off  <= start_off;
                wr_off   <= start_off;
                // Next frame is written only if the reader has let go
                frame_ok <= !swap && !(pending && !restart);
                if (swap) begin
                    wr_buf  <= ~wr_buf;
                    pending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ram[wr_addr] <= cap_pix;
        end
    end

    // ============================================================
    // Read raster
    // ============================================================

    assign line_last = (col == COL_W'(LINE_LEN - 1));
    assign restart   = out_ce & line_last & pending & (row >= ROW_W'(WIDTH));
    assign active    = (col < COL_W'(HEIGHT)) & (row < ROW_W'(WIDTH));
    assign rd_addr   = (rd_buf ? BUF_BASE : '0) + rd_off;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col     <= '0;
            row     <= ROW_W'(WIDTH + 1);
            rd_off  <= '0;
            rd_buf  <= 1'b1;
            rot_ctl <= '{hs: 1'b0, vs: 1'b0, hbl: 1'b1, vbl: 1'b1};
        end else if (out_ce) begin
            rot_ctl.hs  <= (col >= COL_W'(HEIGHT + 8)) && (col < COL_W'(HEIGHT + 10));
            rot_ctl.vs  <= (row == ROW_W'(WIDTH));
            rot_ctl.hbl <= (col >= COL_W'(HEIGHT));
            rot_ctl.vbl <= (row >= ROW_W'(WIDTH));
            if (active) begin
                rd_off <= (rd_off == BUF_LAST) ? '0 : rd_off + 1'b1;
            end
            if (line_last) begin
                col <= '0;
                if (restart) begin
                    row    <= '0;
                    rd_off <= '0;
                    rd_buf <= ~wr_buf;
                end else if (row != ROW_W'(WIDTH + 1)) begin
                    // Parks on the second blank line until a new frame
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_ce) begin
            rd_data <= ram[rd_addr];
        end
    end

    // Margin lines carry black
    assign rot_pix = rot_ctl.vbl ? '0 : rd_data;

    assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (wr_off < BUF_BASE) && (wr_buf != rd_buf))
        else $error("write outside the back buffer");

endmodule

//--- pixel_capture.sv
`timescale 1ns/1ns
// Pixel capture stage
//   Rising-edge detect of the core's pixel clock enable
//   Sync polarity detect, both syncs leave active-high
//   Pixel, blanking and sync registered on each detected edge

module pixel_capture
    import arcade_video_pkg::*;
#(
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          ce_pix,
    input  logic [DW-1:0] pix_in,
    input  video_ctl_t    ctl_in,
    output logic          cap_ce,
    output logic [DW-1:0] cap_pix,
    output video_ctl_t    cap_ctl
);

    localparam int CNT_W = 16;

    logic       ce_d;
    logic       ce_rise;
    logic [1:0] sync_raw;
    logic [1:0] sync_fix;

    assign ce_rise  = ce_pix & ~ce_d;
    assign sync_raw = {ctl_in.hs, ctl_in.vs};

    // ============================================================
    // Sync polarity detect
    // ============================================================

    // The longer phase of a sync is its inactive phase
    for (genvar i = 0; i < 2; i++) begin : g_sync
        logic             sync_d;
        logic [CNT_W-1:0] run_cnt;
        logic [CNT_W-1:0] high_len;
        logic [CNT_W-1:0] low_len;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                sync_d   <= 1'b0;
                run_cnt  <= '0;
                high_len <= '0;
                low_len  <= '0;
            end else begin
                sync_d <= sync_raw[i];
                if (sync_raw[i] != sync_d) begin
                    if (sync_d) begin
                        high_len <= run_cnt;
                    end else begin
                        low_len <= run_cnt;
                    end
                    run_cnt <= '0;
                end else if (run_cnt != '1) begin
                    // Saturates on very long vertical phases
                    run_cnt <= run_cnt + 1'b1;
                end
            end
        end

        assign sync_fix[i] = sync_raw[i] ^ (high_len > low_len);
    end

    // ============================================================
    // Stream registers
    // ============================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ce_d    <= 1'b0;
            cap_ce  <= 1'b0;
            cap_ctl <= '{hs: 1'b0, vs: 1'b0, hbl: 1'b1, vbl: 1'b1};
        end else begin
            ce_d   <= ce_pix;
            cap_ce <= ce_rise;
            if (ce_rise) begin
                cap_ctl.hs  <= sync_fix[1];
                // Frame sync taken at the leading edge of line sync
                if (!cap_ctl.hs && sync_fix[1]) begin
                    cap_ctl.vs <= sync_fix[0];
                end
                cap_ctl.hbl <= ctl_in.hbl;
                // Vertical blank only changes where a line starts
                if (cap_ctl.hbl && !ctl_in.hbl) begin
                    cap_ctl.vbl <= ctl_in.vbl;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ce_rise) begin
            cap_pix <= pix_in;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) cap_ce |=> !cap_ce)
        else $error("cap_ce high on two consecutive cycles");

endmodule

//--- arcade_video_pkg.sv
// Shared video types for the rotating arcade video stage
//   video_ctl_t  sync and blanking levels passed between stages
//   rgb888_t     colour at 8 bits per channel
//   video_out_t  registered top-level video output
//   rot_dir_t    rotation direction of the frame store

package arcade_video_pkg;

    // ============================================================
    // Timing bundle
    // ============================================================

    // All four levels are active-high once past pixel capture
    typedef struct packed {
        logic hs;
        logic vs;
        logic hbl;
        logic vbl;
    } video_ctl_t;

    // ============================================================
    // Colour and output
    // ============================================================

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // One registered output word, ce marks a new pixel
    typedef struct packed {
        logic    ce;
        rgb888_t rgb;
        logic    hs;
        logic    vs;
        logic    de;
    } video_out_t;

    // Direction of the 90 degree turn
    typedef enum logic {
        ROT_CW  = 1'b0,
        ROT_CCW = 1'b1
    } rot_dir_t;

endpackage
